/* rtc_types_pkg.sv */
package rtc_types_pkg;

	//////////////////////////////////////////////////
	// BCD values
	//////////////////////////////////////////////////

	// One decimal digit, 0 to 9
	typedef logic [3:0] bcd_digit_t;

	// Tens digit in the upper nibble
	typedef logic [7:0] bcd_pair_t;

	//////////////////////////////////////////////////
	// Field selection
	//////////////////////////////////////////////////

	localparam int num_fields = 6;

	// Bit 0 second, 1 minute, 2 hour, 3 day, 4 month, 5 year
	typedef logic [num_fields-1:0] field_mask_t;

	// Cursor states in panel order
	typedef enum logic [2:0] {
		st_idle,
		st_second,
		st_minute,
		st_hour,
		st_day,
		st_month,
		st_year
	} setup_state_t;

endpackage

/* rtc_limits_pkg.sv */
package rtc_limits_pkg;

	//////////////////////////////////////////////////
	// Field limits in BCD
	//////////////////////////////////////////////////

	// Time of day, 24-hour
	localparam rtc_types_pkg::bcd_pair_t second_min = 8'h00;
	localparam rtc_types_pkg::bcd_pair_t second_max = 8'h59;

	localparam rtc_types_pkg::bcd_pair_t minute_min = 8'h00;
	localparam rtc_types_pkg::bcd_pair_t minute_max = 8'h59;

	localparam rtc_types_pkg::bcd_pair_t hour_min = 8'h00;
	localparam rtc_types_pkg::bcd_pair_t hour_max = 8'h23;

	// Calendar fields start at one
	localparam rtc_types_pkg::bcd_pair_t day_min = 8'h01;
	localparam rtc_types_pkg::bcd_pair_t day_max = 8'h31;

	localparam rtc_types_pkg::bcd_pair_t month_min = 8'h01;
	localparam rtc_types_pkg::bcd_pair_t month_max = 8'h12;

	// Two-digit year within the century
	localparam rtc_types_pkg::bcd_pair_t year_min = 8'h00;
	localparam rtc_types_pkg::bcd_pair_t year_max = 8'h99;

endpackage

/* field_cursor_fsm.sv */
`timescale 1ns/1ps

module field_cursor_fsm (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       edit,
	input  logic                       step_up,
	input  logic                       step_down,
	input  logic                       move_right,
	input  logic                       move_left,
	output rtc_types_pkg::field_mask_t cursor,
	output rtc_types_pkg::field_mask_t step_up_mask,
	output rtc_types_pkg::field_mask_t step_down_mask
);

	import rtc_types_pkg::*;

	setup_state_t state;
	setup_state_t state_next;
	setup_state_t state_right;
	setup_state_t state_left;

	//////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////////////////////////
	// Cursor decode and neighbours
	//////////////////////////////////////////////////

	// One-hot in a field state, zero in idle
	always_comb begin
		cursor      = '0;
		state_right = st_idle;
		state_left  = st_idle;
		case (state)
			st_second: begin
				cursor[0]   = 1'b1;
				state_right = st_minute;
				state_left  = st_year;
			end
			st_minute: begin
				cursor[1]   = 1'b1;
				state_right = st_hour;
				state_left  = st_second;
			end
			st_hour: begin
				cursor[2]   = 1'b1;
				state_right = st_day;
				state_left  = st_minute;
			end
			st_day: begin
				cursor[3]   = 1'b1;
				state_right = st_month;
				state_left  = st_hour;
			end
			st_month: begin
				cursor[4]   = 1'b1;
				state_right = st_year;
				state_left  = st_day;
			end
			st_year: begin
				cursor[5]   = 1'b1;
				state_right = st_second;
				state_left  = st_month;
			end
			default: begin
				cursor = '0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Next state and step pulses
	//////////////////////////////////////////////////

	always_comb begin
		state_next     = state;
		step_up_mask   = '0;
		step_down_mask = '0;
		if (state == st_idle) begin
			// Steps are ignored until edit is raised
			if (edit) begin
				state_next = st_second;
			end
		end else if (step_up) begin
			step_up_mask = cursor;
		end else if (step_down) begin
			step_down_mask = cursor;
		end else if (move_right) begin
			state_next = state_right;
		end else if (move_left) begin
			state_next = state_left;
		end else if (!edit) begin
			state_next = st_idle;
		end
	end

endmodule

/* bcd_field_counter.sv */
`timescale 1ns/1ps

module bcd_field_counter #(
	parameter rtc_types_pkg::bcd_pair_t min_value = 8'h00,
	parameter rtc_types_pkg::bcd_pair_t max_value = 8'h59
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     up,
	input  logic                     down,
	output rtc_types_pkg::bcd_pair_t value
);

	import rtc_types_pkg::*;

	localparam bcd_digit_t digit_zero = 4'd0;
	localparam bcd_digit_t digit_nine = 4'd9;

	bcd_digit_t tens;
	bcd_digit_t units;
	bcd_digit_t tens_next;
	bcd_digit_t units_next;

	assign value = {tens, units};

	//////////////////////////////////////////////////
	// Digit registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			{tens, units} <= min_value;
		end else begin
			tens  <= tens_next;
			units <= units_next;
		end
	end

	//////////////////////////////////////////////////
	// Step with carry, borrow and wrap
	//////////////////////////////////////////////////

	always_comb begin
		tens_next  = tens;
		units_next = units;
		if (up) begin
			if (value == max_value) begin
				{tens_next, units_next} = min_value;
			end else if (units == digit_nine) begin
				// Carry into the tens digit
				units_next = digit_zero;
				tens_next  = tens + 4'd1;
			end else begin
				units_next = units + 4'd1;
			end
		end else if (down) begin
			if (value == min_value) begin
				{tens_next, units_next} = max_value;
			end else if (units == digit_zero) begin
				// Borrow from the tens digit
				units_next = digit_nine;
				tens_next  = tens - 4'd1;
			end else begin
				units_next = units - 4'd1;
			end
		end
	end

endmodule

/* rtc_setup.sv */
`timescale 1ns/1ps

module rtc_setup (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       edit,
	input  logic                       step_up,
	input  logic                       step_down,
	input  logic                       move_right,
	input  logic                       move_left,
	output rtc_types_pkg::bcd_pair_t   second,
	output rtc_types_pkg::bcd_pair_t   minute,
	output rtc_types_pkg::bcd_pair_t   hour,
	output rtc_types_pkg::bcd_pair_t   day,
	output rtc_types_pkg::bcd_pair_t   month,
	output rtc_types_pkg::bcd_pair_t   year,
	output rtc_types_pkg::field_mask_t cursor
);

	import rtc_types_pkg::*;
	import rtc_limits_pkg::*;

	field_mask_t step_up_mask;
	field_mask_t step_down_mask;

	//////////////////////////////////////////////////
	// Cursor
	//////////////////////////////////////////////////

	field_cursor_fsm u_cursor (
		.clk            (clk),
		.reset          (reset),
		.edit           (edit),
		.step_up        (step_up),
		.step_down      (step_down),
		.move_right     (move_right),
		.move_left      (move_left),
		.cursor         (cursor),
		.step_up_mask   (step_up_mask),
		.step_down_mask (step_down_mask)
	);

	//////////////////////////////////////////////////
	// Field counters
	//////////////////////////////////////////////////

	// Time of day
	bcd_field_counter #(.min_value(second_min), .max_value(second_max)) u_second (
		.clk(clk), .reset(reset),
		.up(step_up_mask[0]), .down(step_down_mask[0]),
		.value(second)
	);

	bcd_field_counter #(.min_value(minute_min), .max_value(minute_max)) u_minute (
		.clk(clk), .reset(reset),
		.up(step_up_mask[1]), .down(step_down_mask[1]),
		.value(minute)
	);

	bcd_field_counter #(.min_value(hour_min), .max_value(hour_max)) u_hour (
		.clk(clk), .reset(reset),
		.up(step_up_mask[2]), .down(step_down_mask[2]),
		.value(hour)
	);

	// Calendar
	bcd_field_counter #(.min_value(day_min), .max_value(day_max)) u_day (
		.clk(clk), .reset(reset),
		.up(step_up_mask[3]), .down(step_down_mask[3]),
		.value(day)
	);

	bcd_field_counter #(.min_value(month_min), .max_value(month_max)) u_month (
		.clk(clk), .reset(reset),
		.up(step_up_mask[4]), .down(step_down_mask[4]),
		.value(month)
	);

	bcd_field_counter #(.min_value(year_min), .max_value(year_max)) u_year (
		.clk(clk), .reset(reset),
		.up(step_up_mask[5]), .down(step_down_mask[5]),
		.value(year)
	);

endmodule

/* rtc_setup_properties.sv */
`timescale 1ns/1ps

module rtc_setup_properties (
	input logic                       clk,
	input logic                       reset,
	input rtc_types_pkg::field_mask_t cursor,
	input rtc_types_pkg::bcd_pair_t   second,
	input rtc_types_pkg::bcd_pair_t   minute,
	input rtc_types_pkg::bcd_pair_t   hour,
	input rtc_types_pkg::bcd_pair_t   day,
	input rtc_types_pkg::bcd_pair_t   month,
	input rtc_types_pkg::bcd_pair_t   year
);

	import rtc_types_pkg::*;
	import rtc_limits_pkg::*;

	// Fields packed in cursor bit order, second in the low byte
	logic [47:0] all_fields;

	assign all_fields = {year, month, day, hour, minute, second};

	function automatic logic is_bcd(bcd_pair_t v);
		return (v[7:4] <= 4'd9) && (v[3:0] <= 4'd9);
	endfunction

	function automatic logic in_range(bcd_pair_t v, bcd_pair_t lo, bcd_pair_t hi);
		return (v >= lo) && (v <= hi);
	endfunction

	//////////////////////////////////////////////////
	// Cursor and value ranges
	//////////////////////////////////////////////////

	cursor_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(cursor))
		else $error("cursor has more than one field selected");

	digits_bcd: assert property (@(posedge clk) disable iff (reset)
		is_bcd(second) && is_bcd(minute) && is_bcd(hour) &&
		is_bcd(day) && is_bcd(month) && is_bcd(year))
		else $error("a field holds a digit above nine");

	fields_in_range: assert property (@(posedge clk) disable iff (reset)
		in_range(second, second_min, second_max) && in_range(minute, minute_min, minute_max) &&
		in_range(hour, hour_min, hour_max) && in_range(day, day_min, day_max) &&
		in_range(month, month_min, month_max) && in_range(year, year_min, year_max))
		else $error("a field is outside its limits");

	//////////////////////////////////////////////////
	// Only the selected field moves
	//////////////////////////////////////////////////

	for (genvar i = 0; i < num_fields; i++) begin : g_change
		field_changes_selected: assert property (@(posedge clk) disable iff (reset)
			(all_fields[8*i +: 8] != $past(all_fields[8*i +: 8])) |-> $past(cursor[i]))
			else $error("field %0d changed while not selected", i);
	end

endmodule

/* tb_rtc_setup.sv */
`timescale 1ns/1ps

module tb_rtc_setup;

	import rtc_types_pkg::*;

	localparam int reset_cycles = 16;
	localparam int name_chars = 24;

	logic        clk;
	logic        reset;
	logic        edit;
	logic        step_up;
	logic        step_down;
	logic        move_right;
	logic        move_left;
	bcd_pair_t   second;
	bcd_pair_t   minute;
	bcd_pair_t   hour;
	bcd_pair_t   day;
	bcd_pair_t   month;
	bcd_pair_t   year;
	field_mask_t cursor;

	// Pattern table with one entry per command line
	logic [7:0]              cmd_q[$];
	field_mask_t             cursor_q[$];
	logic [47:0]             fields_q[$];
	int                      group_q[$];
	logic [8*name_chars-1:0] name_q[$];

	bit load_ok;
	int cycles = 0;
	int cycle_limit = 0;
	int current_pattern;
	int group_errors;
	int tests_passed;
	int tests_failed;

	rtc_setup u_rtc_setup (
		.clk(clk), .reset(reset), .edit(edit),
		.step_up(step_up), .step_down(step_down),
		.move_right(move_right), .move_left(move_left),
		.second(second), .minute(minute), .hour(hour),
		.day(day), .month(month), .year(year),
		.cursor(cursor)
	);

	bind rtc_setup rtc_setup_properties u_properties (
		.clk(clk), .reset(reset), .cursor(cursor),
		.second(second), .minute(minute), .hour(hour),
		.day(day), .month(month), .year(year)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("The run timed out after %0d cycles before all patterns were applied",
				cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Pattern file
	//////////////////////////////////////////////////

	task automatic read_patterns();
		int                      fd;
		int                      code;
		int                      group_index;
		logic [7:0]              ch;
		logic [8*name_chars-1:0] name;
		logic [8*120-1:0]        rest;
		field_mask_t             c;
		bcd_pair_t               s;
		bcd_pair_t               m;
		bcd_pair_t               h;
		bcd_pair_t               d;
		bcd_pair_t               mo;
		bcd_pair_t               y;
		group_index = -1;
		load_ok = 1'b1;
		fd = $fopen("rtc_setup_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file rtc_setup_patterns.txt");
			load_ok = 1'b0;
		end else begin
			code = $fscanf(fd, " %c", ch);
			while (code == 1 && load_ok) begin
				if (ch == "#") begin
					code = $fgets(rest, fd);
				end else if (ch == "G") begin
					code = $fscanf(fd, "%s", name);
					name_q.push_back(name);
					group_index++;
				end else begin
					code = $fscanf(fd, "%h %h %h %h %h %h %h", c, s, m, h, d, mo, y);
					if (code != 7 || group_index < 0) begin
						$display("Pattern line for command %c is malformed or has no group", ch);
						load_ok = 1'b0;
					end else begin
						cmd_q.push_back(ch);
						cursor_q.push_back(c);
						fields_q.push_back({y, mo, d, h, m, s});
						group_q.push_back(group_index);
					end
				end
				code = $fscanf(fd, " %c", ch);
			end
			$fclose(fd);
			if (cmd_q.size() == 0) begin
				$display("The pattern file holds no commands");
				load_ok = 1'b0;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Drive, compare, report
	//////////////////////////////////////////////////

	// Strobes last one cycle while edit is held as a level
	task automatic apply_command(logic [7:0] cmd);
		step_up    = 1'b0;
		step_down  = 1'b0;
		move_right = 1'b0;
		move_left  = 1'b0;
		case (cmd)
			"E": edit = 1'b1;
			"X": edit = 1'b0;
			"U": step_up = 1'b1;
			"D": step_down = 1'b1;
			"R": move_right = 1'b1;
			"L": move_left = 1'b1;
			"B": begin
				step_up    = 1'b1;
				move_right = 1'b1;
			end
			"N": ;
			default: begin
				$display("Pattern %0d has the unknown command %c", current_pattern, cmd);
				group_errors++;
			end
		endcase
	endtask

	function automatic setup_state_t state_for_cursor(field_mask_t mask);
		setup_state_t st;
		case (mask)
			6'b000001: st = st_second;
			6'b000010: st = st_minute;
			6'b000100: st = st_hour;
			6'b001000: st = st_day;
			6'b010000: st = st_month;
			6'b100000: st = st_year;
			default:   st = st_idle;
		endcase
		return st;
	endfunction

	task automatic check_cursor(field_mask_t expected, field_mask_t actual);
		setup_state_t st;
		st = state_for_cursor(expected);
		if (actual !== expected) begin
			$display("MISMATCH cursor at pattern %0d: expected %h (%s), got %h",
				current_pattern, expected, st.name(), actual);
			group_errors++;
		end
	endtask

	task automatic check_field(string name, bcd_pair_t expected, bcd_pair_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s at pattern %0d: expected %h, got %h",
				name, current_pattern, expected, actual);
			group_errors++;
		end
	endtask

	task automatic check_outputs(field_mask_t exp_cursor, logic [47:0] exp_fields);
		check_cursor(exp_cursor, cursor);
		check_field("second", exp_fields[7:0], second);
		check_field("minute", exp_fields[15:8], minute);
		check_field("hour", exp_fields[23:16], hour);
		check_field("day", exp_fields[31:24], day);
		check_field("month", exp_fields[39:32], month);
		check_field("year", exp_fields[47:40], year);
	endtask

	task automatic report_test(string name);
		if (group_errors == 0) begin
			tests_passed++;
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, group_errors);
		end
		group_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		int prev_group;
		reset        = 1'b1;
		edit         = 1'b0;
		step_up      = 1'b0;
		step_down    = 1'b0;
		move_right   = 1'b0;
		move_left    = 1'b0;
		group_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		current_pattern = 0;
		read_patterns();
		if (load_ok) begin
			cycle_limit = reset_cycles + 4 * cmd_q.size();
		end
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (!load_ok) begin
			$display("The run stopped because the patterns could not be loaded");
			$display("SOME TESTS FAILED");
		end else begin
			// Day and month reset to 01 and all other fields to 00
			check_outputs('0, {8'h00, 8'h01, 8'h01, 8'h00, 8'h00, 8'h00});
			report_test("reset_values");
			prev_group = group_q[0];
			foreach (cmd_q[i]) begin
				if (group_q[i] != prev_group) begin
					report_test($sformatf("%0s", name_q[prev_group]));
					prev_group = group_q[i];
				end
				current_pattern = i + 1;
				apply_command(cmd_q[i]);
				@(negedge clk);
				check_outputs(cursor_q[i], fields_q[i]);
			end
			apply_command("N");
			report_test($sformatf("%0s", name_q[prev_group]));
			$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
			if (tests_failed == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
		end
		$finish;
	end

endmodule

/* list.f */
rtc_types_pkg.sv
rtc_limits_pkg.sv
field_cursor_fsm.sv
bcd_field_counter.sv
rtc_setup.sv
rtc_setup_properties.sv
tb_rtc_setup.sv

/* run.sh */
#!/bin/bash
# Build the rtc_setup testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
	--top-module tb_rtc_setup -o sim_rtc_setup || exit 1
output=$(./obj_dir/sim_rtc_setup)
echo "$output"
echo "$output" | grep -q "ALL TESTS PASSED" && echo "Result: pass" \
	|| { echo "Result: fail"; exit 1; }

/* rtc_setup_patterns.txt */
# cmd cursor second minute hour day month year, all values in hex, expected one clock later
# G <name> starts a test group, lines starting with # are comments
G idle_ignores_strobes
N 00 00 00 00 01 01 00
U 00 00 00 00 01 01 00
D 00 00 00 00 01 01 00
R 00 00 00 00 01 01 00
L 00 00 00 00 01 01 00
B 00 00 00 00 01 01 00
G cursor_walk
E 01 00 00 00 01 01 00
R 02 00 00 00 01 01 00
R 04 00 00 00 01 01 00
R 08 00 00 00 01 01 00
R 10 00 00 00 01 01 00
R 20 00 00 00 01 01 00
R 01 00 00 00 01 01 00
L 20 00 00 00 01 01 00
L 10 00 00 00 01 01 00
L 08 00 00 00 01 01 00
L 04 00 00 00 01 01 00
L 02 00 00 00 01 01 00
L 01 00 00 00 01 01 00
G wrap_at_limits
D 01 59 00 00 01 01 00
U 01 00 00 00 01 01 00
U 01 01 00 00 01 01 00
R 02 01 00 00 01 01 00
D 02 01 59 00 01 01 00
U 02 01 00 00 01 01 00
R 04 01 00 00 01 01 00
D 04 01 00 23 01 01 00
U 04 01 00 00 01 01 00
D 04 01 00 23 01 01 00
R 08 01 00 23 01 01 00
D 08 01 00 23 31 01 00
U 08 01 00 23 01 01 00
R 10 01 00 23 01 01 00
D 10 01 00 23 01 12 00
U 10 01 00 23 01 01 00
R 20 01 00 23 01 01 00
D 20 01 00 23 01 01 99
U 20 01 00 23 01 01 00
G carry_borrow
L 10 01 00 23 01 01 00
D 10 01 00 23 01 12 00
D 10 01 00 23 01 11 00
D 10 01 00 23 01 10 00
D 10 01 00 23 01 09 00
U 10 01 00 23 01 10 00
D 10 01 00 23 01 09 00
L 08 01 00 23 01 09 00
D 08 01 00 23 31 09 00
D 08 01 00 23 30 09 00
D 08 01 00 23 29 09 00
U 08 01 00 23 30 09 00
G idle_resume
X 00 01 00 23 30 09 00
U 00 01 00 23 30 09 00
R 00 01 00 23 30 09 00
E 01 01 00 23 30 09 00
U 01 02 00 23 30 09 00
G step_priority
B 01 03 00 23 30 09 00
R 02 03 00 23 30 09 00
B 02 03 01 23 30 09 00
X 00 03 01 23 30 09 00
